//--- tb.f
+incdir+logic
logic/huff_types_pkg.sv
logic/huff_ctrl_pkg.sv
logic/huff_histogram.sv
logic/huff_sorter.sv
logic/huff_merger.sv
logic/huff_code_builder.sv
logic/huffman_top.sv
dv/huffman_chk.sv
dv/huffman_tb.sv

//--- dv/huffman_tb.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huffman_tb;

	// summed stream cycles rounded up and 80 more cycles per test
	localparam int STREAM_TOTAL   = 200;
	localparam int TIMEOUT_CYCLES = STREAM_TOTAL + 80 * 5;

	logic                      clk;
	logic                      reset;
	logic                      gray_valid;
	huff_types_pkg::pixel_t    gray_data;
	logic                      cnt_valid;
	logic                      code_valid;
	huff_types_pkg::count_t    cnt1, cnt2, cnt3, cnt4, cnt5, cnt6;
	huff_types_pkg::code_t     hc1, hc2, hc3, hc4, hc5, hc6;
	huff_types_pkg::len_mask_t m1, m2, m3, m4, m5, m6;

	// numbered outputs gathered by symbol
	huff_types_pkg::count_t    dut_cnt [`HUFF_NUM_SYMBOLS];
	huff_types_pkg::code_t     dut_code [`HUFF_NUM_SYMBOLS];
	huff_types_pkg::len_mask_t dut_len [`HUFF_NUM_SYMBOLS];

	// expected results and current stimulus
	int                     exp_cnt [`HUFF_NUM_SYMBOLS];
	int                     exp_code [`HUFF_NUM_SYMBOLS];
	int                     exp_len [`HUFF_NUM_SYMBOLS];
	huff_types_pkg::pixel_t stream_q [$];

	integer seed;
	int     cycles = 0;
	int     check_count = 0;
	int     error_count = 0;

	huffman_top UUT (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.cnt1       (cnt1),
		.cnt2       (cnt2),
		.cnt3       (cnt3),
		.cnt4       (cnt4),
		.cnt5       (cnt5),
		.cnt6       (cnt6),
		.code_valid (code_valid),
		.hc1        (hc1),
		.hc2        (hc2),
		.hc3        (hc3),
		.hc4        (hc4),
		.hc5        (hc5),
		.hc6        (hc6),
		.m1         (m1),
		.m2         (m2),
		.m3         (m3),
		.m4         (m4),
		.m5         (m5),
		.m6         (m6)
	);

	assign dut_cnt[0] = cnt1;
	assign dut_cnt[1] = cnt2;
	assign dut_cnt[2] = cnt3;
	assign dut_cnt[3] = cnt4;
	assign dut_cnt[4] = cnt5;
	assign dut_cnt[5] = cnt6;
	assign dut_code[0] = hc1;
	assign dut_code[1] = hc2;
	assign dut_code[2] = hc3;
	assign dut_code[3] = hc4;
	assign dut_code[4] = hc5;
	assign dut_code[5] = hc6;
	assign dut_len[0] = m1;
	assign dut_len[1] = m2;
	assign dut_len[2] = m3;
	assign dut_len[3] = m4;
	assign dut_len[4] = m5;
	assign dut_len[5] = m6;

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected,
				actual);
		end
	endtask

	// ==========================================================
	// reference model
	// ==========================================================
	task automatic compute_model();
		int node_cnt [`HUFF_NUM_SYMBOLS];
		int node_mask [`HUFF_NUM_SYMBOLS];
		int hi [`HUFF_MERGES];
		int lo [`HUFF_MERGES];
		int best;
		int tmp;
		int live;
		int p;
		for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
			exp_cnt[s] = 0;
			exp_code[s] = 0;
			exp_len[s] = 0;
		end
		foreach (stream_q[i]) begin
			if (stream_q[i] >= 1 && stream_q[i] <= `HUFF_NUM_SYMBOLS) begin
				exp_cnt[stream_q[i] - 1]++;
			end
		end
		for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
			node_cnt[s] = exp_cnt[s];
			node_mask[s] = 1 << s;
		end
		// bigger count first and lower symbol first on a tie
		for (int i = 0; i < `HUFF_NUM_SYMBOLS - 1; i++) begin
			best = i;
			for (int j = i + 1; j < `HUFF_NUM_SYMBOLS; j++) begin
				if (node_cnt[j] > node_cnt[best] ||
						(node_cnt[j] == node_cnt[best] && node_mask[j] < node_mask[best])) begin
					best = j;
				end
			end
			tmp = node_cnt[i];
			node_cnt[i] = node_cnt[best];
			node_cnt[best] = tmp;
			tmp = node_mask[i];
			node_mask[i] = node_mask[best];
			node_mask[best] = tmp;
		end
		live = `HUFF_NUM_SYMBOLS;
		for (int r = 0; r < `HUFF_MERGES; r++) begin
			hi[r] = node_mask[live - 2];
			lo[r] = node_mask[live - 1];
			node_cnt[live - 2] += node_cnt[live - 1];
			node_mask[live - 2] |= node_mask[live - 1];
			live--;
			// merged node passes only strictly smaller counts
			p = live - 1;
			while (p > 0 && node_cnt[p] > node_cnt[p - 1]) begin
				tmp = node_cnt[p];
				node_cnt[p] = node_cnt[p - 1];
				node_cnt[p - 1] = tmp;
				tmp = node_mask[p];
				node_mask[p] = node_mask[p - 1];
				node_mask[p - 1] = tmp;
				p--;
			end
		end
		// root merge gives the leading code bit
		for (int r = `HUFF_MERGES - 1; r >= 0; r--) begin
			for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
				if ((hi[r] >> s) & 1) begin
					exp_code[s] = exp_code[s] << 1;
					exp_len[s] = (exp_len[s] << 1) | 1;
				end else if ((lo[r] >> s) & 1) begin
					exp_code[s] = (exp_code[s] << 1) | 1;
					exp_len[s] = (exp_len[s] << 1) | 1;
				end
			end
		end
	endtask

	// ==========================================================
	// stimulus and response helpers
	// ==========================================================
	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		gray_valid <= 1'b0;
		gray_data <= '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("cnt_valid", cnt_valid, 0);
		check_value("code_valid", code_valid, 0);
		for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
			check_value($sformatf("cnt%0d", s + 1), dut_cnt[s], 0);
			check_value($sformatf("hc%0d", s + 1), dut_code[s], 0);
			check_value($sformatf("m%0d", s + 1), dut_len[s], 0);
		end
	endtask

	// interleaves the symbols until every count is used up
	task automatic add_round_robin(input int c1, c2, c3, c4, c5, c6);
		int left [`HUFF_NUM_SYMBOLS];
		int added;
		left = '{c1, c2, c3, c4, c5, c6};
		do begin
			added = 0;
			for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
				if (left[s] > 0) begin
					stream_q.push_back(huff_types_pkg::pixel_t'(s + 1));
					left[s]--;
					added++;
				end
			end
		end while (added != 0);
	endtask

	task automatic check_counts();
		for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
			check_value($sformatf("cnt%0d", s + 1), dut_cnt[s], exp_cnt[s]);
		end
	endtask

	task automatic check_codes();
		for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
			check_value($sformatf("hc%0d", s + 1), dut_code[s], exp_code[s]);
			check_value($sformatf("m%0d", s + 1), dut_len[s], exp_len[s]);
		end
	endtask

	task automatic run_frame();
		compute_model();
		foreach (stream_q[i]) begin
			@(posedge clk);
			gray_valid <= 1'b1;
			gray_data <= stream_q[i];
		end
		@(posedge clk);
		gray_valid <= 1'b0;
		gray_data <= '0;
		// strobe follows the end-of-stream cycle by one cycle
		@(negedge clk);
		check_value("cnt_valid", cnt_valid, 0);
		@(negedge clk);
		check_value("cnt_valid", cnt_valid, 1);
		check_counts();
		while (!code_valid) begin
			@(negedge clk);
		end
		check_codes();
	endtask

	// ==========================================================
	// directed tests
	// ==========================================================
	task automatic test_distinct_counts();
		apply_reset();
		stream_q.delete();
		add_round_robin(3, 9, 1, 6, 12, 4);
		run_frame();
	endtask

	// three leaves tie at 2 and the first merged node also sums to 2
	task automatic test_ties();
		apply_reset();
		stream_q.delete();
		add_round_robin(3, 2, 2, 1, 1, 2);
		run_frame();
	endtask

	task automatic test_zero_and_ignored();
		apply_reset();
		stream_q.delete();
		stream_q.push_back(8'd0);
		stream_q.push_back(8'd200);
		add_round_robin(5, 0, 3, 7, 0, 2);
		stream_q.push_back(8'd7);
		stream_q.push_back(8'd0);
		stream_q.push_back(8'd200);
		stream_q.push_back(8'd7);
		stream_q.push_back(8'd0);
		run_frame();
	endtask

	task automatic test_random_stream();
		integer r;
		apply_reset();
		stream_q.delete();
		// values 0 and 7 fall outside the alphabet
		for (int i = 0; i < 100; i++) begin
			r = $random(seed);
			stream_q.push_back(huff_types_pkg::pixel_t'(r & 7));
		end
		run_frame();
	endtask

	task automatic test_end_of_frame();
		apply_reset();
		stream_q.delete();
		add_round_robin(2, 5, 3, 1, 4, 5);
		run_frame();
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			gray_valid <= 1'b1;
			gray_data <= huff_types_pkg::pixel_t'((i % 6) + 1);
			@(posedge clk);
			gray_valid <= 1'b0;
			gray_data <= '0;
			@(negedge clk);
			check_value("code_valid", code_valid, 1);
			check_value("cnt_valid", cnt_valid, 0);
		end
		repeat (3) @(negedge clk);
		check_value("code_valid", code_valid, 1);
		check_counts();
		check_codes();
		// frame cleared only by reset
		apply_reset();
	endtask

	initial begin
		seed = 56276;
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = '0;
		test_distinct_counts();
		test_ties();
		test_zero_and_ignored();
		test_random_stream();
		test_end_of_frame();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- dv/huffman_chk.sv
`timescale 1ns/1ns

module huffman_chk (
	input logic                   clk,
	input logic                   reset,
	input logic                   cnt_valid,
	input logic                   code_valid,
	input huff_types_pkg::count_t cnt1,
	input huff_types_pkg::count_t cnt2,
	input huff_types_pkg::count_t cnt3,
	input huff_types_pkg::count_t cnt4,
	input huff_types_pkg::count_t cnt5,
	input huff_types_pkg::count_t cnt6
);

	// set once the count strobe has gone out
	logic frozen;

	always @(posedge clk) begin
		if (reset) begin
			frozen <= 1'b0;
		end else if (cnt_valid) begin
			frozen <= 1'b1;
		end
	end

	// strobe is a single cycle
	cnt_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |=> !cnt_valid)
		else $error("cnt_valid stayed high for more than one cycle");

	// only reset clears code_valid
	code_valid_holds: assert property (@(posedge clk)
		(code_valid && !reset) |=> (code_valid || reset))
		else $error("code_valid fell without reset");

	counts_frozen: assert property (@(posedge clk) disable iff (reset)
		(cnt_valid || frozen) |=> $stable({cnt1, cnt2, cnt3, cnt4, cnt5, cnt6}))
		else $error("counts changed after cnt_valid");

endmodule

bind huffman_top huffman_chk u_chk (
	.clk        (clk),
	.reset      (reset),
	.cnt_valid  (cnt_valid),
	.code_valid (code_valid),
	.cnt1       (cnt1),
	.cnt2       (cnt2),
	.cnt3       (cnt3),
	.cnt4       (cnt4),
	.cnt5       (cnt5),
	.cnt6       (cnt6)
);

//--- logic/huffman_top.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huffman_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      gray_valid,
	input  huff_types_pkg::pixel_t    gray_data,
	output logic                      cnt_valid,
	output huff_types_pkg::count_t    cnt1,
	output huff_types_pkg::count_t    cnt2,
	output huff_types_pkg::count_t    cnt3,
	output huff_types_pkg::count_t    cnt4,
	output huff_types_pkg::count_t    cnt5,
	output huff_types_pkg::count_t    cnt6,
	output logic                      code_valid,
	output huff_types_pkg::code_t     hc1,
	output huff_types_pkg::code_t     hc2,
	output huff_types_pkg::code_t     hc3,
	output huff_types_pkg::code_t     hc4,
	output huff_types_pkg::code_t     hc5,
	output huff_types_pkg::code_t     hc6,
	output huff_types_pkg::len_mask_t m1,
	output huff_types_pkg::len_mask_t m2,
	output huff_types_pkg::len_mask_t m3,
	output huff_types_pkg::len_mask_t m4,
	output huff_types_pkg::len_mask_t m5,
	output huff_types_pkg::len_mask_t m6
);

	// stage hand-off
	huff_types_pkg::count_t    counts [`HUFF_NUM_SYMBOLS];
	logic                      sort_done;
	huff_types_pkg::count_t    sorted_cnt [`HUFF_NUM_SYMBOLS];
	huff_types_pkg::sym_mask_t sorted_mask [`HUFF_NUM_SYMBOLS];
	logic                      merge_done;
	huff_types_pkg::sym_mask_t hi_mask [`HUFF_MERGES];
	huff_types_pkg::sym_mask_t lo_mask [`HUFF_MERGES];
	huff_types_pkg::code_t     codes [`HUFF_NUM_SYMBOLS];
	huff_types_pkg::len_mask_t lens [`HUFF_NUM_SYMBOLS];

	// ==========================================================
	// pipeline of stages
	// ==========================================================
	huff_histogram u_histogram (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.counts     (counts)
	);

	huff_sorter u_sorter (
		.clk         (clk),
		.reset       (reset),
		.cnt_valid   (cnt_valid),
		.counts      (counts),
		.sort_done   (sort_done),
		.sorted_cnt  (sorted_cnt),
		.sorted_mask (sorted_mask)
	);

	huff_merger u_merger (
		.clk         (clk),
		.reset       (reset),
		.sort_done   (sort_done),
		.sorted_cnt  (sorted_cnt),
		.sorted_mask (sorted_mask),
		.merge_done  (merge_done),
		.hi_mask     (hi_mask),
		.lo_mask     (lo_mask)
	);

	huff_code_builder u_code_builder (
		.clk        (clk),
		.reset      (reset),
		.merge_done (merge_done),
		.hi_mask    (hi_mask),
		.lo_mask    (lo_mask),
		.code_valid (code_valid),
		.codes      (codes),
		.lens       (lens)
	);

	// numbered outputs, entry 0 is symbol 1
	assign cnt1 = counts[0];
	assign cnt2 = counts[1];
	assign cnt3 = counts[2];
	assign cnt4 = counts[3];
	assign cnt5 = counts[4];
	assign cnt6 = counts[5];

	assign hc1 = codes[0];
	assign hc2 = codes[1];
	assign hc3 = codes[2];
	assign hc4 = codes[3];
	assign hc5 = codes[4];
	assign hc6 = codes[5];

	assign m1 = lens[0];
	assign m2 = lens[1];
	assign m3 = lens[2];
	assign m4 = lens[3];
	assign m5 = lens[4];
	assign m6 = lens[5];

endmodule

//--- logic/huff_code_builder.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_code_builder (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      merge_done,
	input  huff_types_pkg::sym_mask_t hi_mask [`HUFF_MERGES],
	input  huff_types_pkg::sym_mask_t lo_mask [`HUFF_MERGES],
	output logic                      code_valid,
	output huff_types_pkg::code_t     codes [`HUFF_NUM_SYMBOLS],
	output huff_types_pkg::len_mask_t lens [`HUFF_NUM_SYMBOLS]
);

	huff_ctrl_pkg::build_state_t state;
	huff_ctrl_pkg::round_t       round;

	assign code_valid = (state == huff_ctrl_pkg::BLD_DONE);

	// ==========================================================
	// walk rounds from the root merge back to the first one
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= huff_ctrl_pkg::BLD_IDLE;
			round <= '0;
			for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
				codes[s] <= '0;
				lens[s]  <= '0;
			end
		end else begin
			case (state)
				huff_ctrl_pkg::BLD_IDLE: begin
					if (merge_done) begin
						state <= huff_ctrl_pkg::BLD_WALK;
						round <= huff_ctrl_pkg::round_t'(`HUFF_MERGES - 1);
					end
				end
				huff_ctrl_pkg::BLD_WALK: begin
					// hi side takes a 0, lo side a 1
					for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
						if (hi_mask[round][s]) begin
							codes[s] <= {codes[s][`HUFF_CODE_W-2:0], 1'b0};
							lens[s]  <= {lens[s][`HUFF_CODE_W-2:0], 1'b1};
						end else if (lo_mask[round][s]) begin
							codes[s] <= {codes[s][`HUFF_CODE_W-2:0], 1'b1};
							lens[s]  <= {lens[s][`HUFF_CODE_W-2:0], 1'b1};
						end
					end
					if (round == '0) begin
						state <= huff_ctrl_pkg::BLD_DONE;
					end else begin
						round <= round - 1'b1;
					end
				end
				default: begin
					// codes held until reset
					state <= huff_ctrl_pkg::BLD_DONE;
				end
			endcase
		end
	end

endmodule

//--- logic/huff_merger.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_merger (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      sort_done,
	input  huff_types_pkg::count_t    sorted_cnt [`HUFF_NUM_SYMBOLS],
	input  huff_types_pkg::sym_mask_t sorted_mask [`HUFF_NUM_SYMBOLS],
	output logic                      merge_done,
	output huff_types_pkg::sym_mask_t hi_mask [`HUFF_MERGES],
	output huff_types_pkg::sym_mask_t lo_mask [`HUFF_MERGES]
);

	huff_ctrl_pkg::merge_state_t state;
	huff_ctrl_pkg::round_t       round;
	// number of live entries in the list
	huff_ctrl_pkg::step_t        len;
	// current slot of the merged node
	huff_ctrl_pkg::step_t        pos;

	// working list, highest rank at 0
	huff_types_pkg::count_t    list_cnt [`HUFF_NUM_SYMBOLS];
	huff_types_pkg::sym_mask_t list_mask [`HUFF_NUM_SYMBOLS];

	// node bubbles up only past strictly smaller counts
	logic move_up;

	assign move_up = (pos != '0) && (list_cnt[pos] > list_cnt[pos - 1'b1]);

	// ==========================================================
	// round control
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= huff_ctrl_pkg::MRG_IDLE;
			round      <= '0;
			len        <= '0;
			pos        <= '0;
			merge_done <= 1'b0;
		end else begin
			merge_done <= 1'b0;
			case (state)
				huff_ctrl_pkg::MRG_IDLE: begin
					if (sort_done) begin
						state <= huff_ctrl_pkg::MRG_POP;
						round <= '0;
						len   <= huff_ctrl_pkg::step_t'(`HUFF_NUM_SYMBOLS);
					end
				end
				huff_ctrl_pkg::MRG_POP: begin
					// two entries leave, the merged one takes the upper slot
					state <= huff_ctrl_pkg::MRG_INSERT;
					len   <= len - 1'b1;
					pos   <= len - 2'd2;
				end
				huff_ctrl_pkg::MRG_INSERT: begin
					if (move_up) begin
						pos <= pos - 1'b1;
					end else if (round == huff_ctrl_pkg::round_t'(`HUFF_MERGES - 1)) begin
						state      <= huff_ctrl_pkg::MRG_DONE;
						merge_done <= 1'b1;
					end else begin
						state <= huff_ctrl_pkg::MRG_POP;
						round <= round + 1'b1;
					end
				end
				default: begin
					state <= huff_ctrl_pkg::MRG_DONE;
				end
			endcase
		end
	end

	// ==========================================================
	// list and merge records
	// ==========================================================
	always_ff @(posedge clk) begin
		case (state)
			huff_ctrl_pkg::MRG_IDLE: begin
				if (sort_done) begin
					list_cnt  <= sorted_cnt;
					list_mask <= sorted_mask;
				end
			end
			huff_ctrl_pkg::MRG_POP: begin
				// second-to-last is hi, last is lo
				hi_mask[round]         <= list_mask[len - 2'd2];
				lo_mask[round]         <= list_mask[len - 1'b1];
				list_cnt[len - 2'd2]   <= list_cnt[len - 2'd2] + list_cnt[len - 1'b1];
				list_mask[len - 2'd2]  <= list_mask[len - 2'd2] | list_mask[len - 1'b1];
			end
			huff_ctrl_pkg::MRG_INSERT: begin
				if (move_up) begin
					list_cnt[pos]          <= list_cnt[pos - 1'b1];
					list_mask[pos]         <= list_mask[pos - 1'b1];
					list_cnt[pos - 1'b1]   <= list_cnt[pos];
					list_mask[pos - 1'b1]  <= list_mask[pos];
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- logic/huff_sorter.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_sorter (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cnt_valid,
	input  huff_types_pkg::count_t    counts [`HUFF_NUM_SYMBOLS],
	output logic                      sort_done,
	output huff_types_pkg::count_t    sorted_cnt [`HUFF_NUM_SYMBOLS],
	output huff_types_pkg::sym_mask_t sorted_mask [`HUFF_NUM_SYMBOLS]
);

	huff_ctrl_pkg::sort_state_t state;
	huff_ctrl_pkg::step_t       pass;

	// index of the lowest symbol in a node
	function automatic huff_ctrl_pkg::step_t low_bit(input huff_types_pkg::sym_mask_t m);
		huff_ctrl_pkg::step_t idx;
		idx = '0;
		for (int b = `HUFF_NUM_SYMBOLS - 1; b >= 0; b--) begin
			if (m[b]) begin
				idx = huff_ctrl_pkg::step_t'(b);
			end
		end
		return idx;
	endfunction

	// rank rule: bigger count first, then lower symbol first
	function automatic logic outranks(
		input huff_types_pkg::count_t    cnt_a,
		input huff_types_pkg::sym_mask_t mask_a,
		input huff_types_pkg::count_t    cnt_b,
		input huff_types_pkg::sym_mask_t mask_b
	);
		if (cnt_a != cnt_b) begin
			return cnt_a > cnt_b;
		end
		return low_bit(mask_a) < low_bit(mask_b);
	endfunction

	// ==========================================================
	// odd-even transposition, one pass per cycle
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= huff_ctrl_pkg::SORT_IDLE;
			pass      <= '0;
			sort_done <= 1'b0;
		end else begin
			sort_done <= 1'b0;
			case (state)
				huff_ctrl_pkg::SORT_IDLE: begin
					if (cnt_valid) begin
						state <= huff_ctrl_pkg::SORT_PASS;
						pass  <= '0;
					end
				end
				huff_ctrl_pkg::SORT_PASS: begin
					if (pass == huff_ctrl_pkg::step_t'(`HUFF_NUM_SYMBOLS - 1)) begin
						state     <= huff_ctrl_pkg::SORT_DONE;
						sort_done <= 1'b1;
					end else begin
						pass <= pass + 1'b1;
					end
				end
				default: begin
					state <= huff_ctrl_pkg::SORT_DONE;
				end
			endcase
		end
	end

	// leaf list, position 0 holds the highest rank
	always_ff @(posedge clk) begin
		if (state == huff_ctrl_pkg::SORT_IDLE && cnt_valid) begin
			for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
				sorted_cnt[i]  <= counts[i];
				sorted_mask[i] <= huff_types_pkg::sym_mask_t'(1) << i;
			end
		end else if (state == huff_ctrl_pkg::SORT_PASS) begin
			// even passes pair (0,1),(2,3).. and odd passes (1,2),(3,4)..
			for (int i = 0; i < `HUFF_NUM_SYMBOLS - 1; i++) begin
				if ((i % 2) == pass[0] && outranks(sorted_cnt[i+1], sorted_mask[i+1],
						sorted_cnt[i], sorted_mask[i])) begin
					sorted_cnt[i]    <= sorted_cnt[i+1];
					sorted_mask[i]   <= sorted_mask[i+1];
					sorted_cnt[i+1]  <= sorted_cnt[i];
					sorted_mask[i+1] <= sorted_mask[i];
				end
			end
		end
	end

endmodule

//--- logic/huff_histogram.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_histogram (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   gray_valid,
	input  huff_types_pkg::pixel_t gray_data,
	output logic                   cnt_valid,
	output huff_types_pkg::count_t counts [`HUFF_NUM_SYMBOLS]
);

	// stream has started
	logic seen;
	// stream has ended, frame is frozen until reset
	logic closed;

	always_ff @(posedge clk) begin
		if (reset) begin
			seen      <= 1'b0;
			closed    <= 1'b0;
			cnt_valid <= 1'b0;
			for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
				counts[i] <= '0;
			end
		end else begin
			cnt_valid <= 1'b0;
			if (!closed) begin
				if (gray_valid) begin
					seen <= 1'b1;
					// symbol i+1 lands in counter i, other values drop out
					for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
						if (gray_data == huff_types_pkg::pixel_t'(i + 1)) begin
							counts[i] <= counts[i] + 1'b1;
						end
					end
				end else if (seen) begin
					// first low cycle after the run
					closed    <= 1'b1;
					cnt_valid <= 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/huff_ctrl_pkg.sv
`include "huff_settings.svh"

package huff_ctrl_pkg;

	// ==========================================================
	// stage state machines
	// ==========================================================
	typedef enum logic [1:0] {SORT_IDLE, SORT_PASS, SORT_DONE} sort_state_t;

	typedef enum logic [1:0] {MRG_IDLE, MRG_POP, MRG_INSERT, MRG_DONE} merge_state_t;

	typedef enum logic [1:0] {BLD_IDLE, BLD_WALK, BLD_DONE} build_state_t;

	// ==========================================================
	// counters shared by the stages
	// ==========================================================
	// merge round number, 0 to HUFF_MERGES-1
	typedef logic [$clog2(`HUFF_MERGES)-1:0] round_t;

	// list position, live length or sort pass, up to HUFF_NUM_SYMBOLS
	typedef logic [$clog2(`HUFF_NUM_SYMBOLS+1)-1:0] step_t;

endpackage

//--- logic/huff_types_pkg.sv
`include "huff_settings.svh"

package huff_types_pkg;

	// incoming gray value
	typedef logic [`HUFF_DATA_W-1:0] pixel_t;

	// occurrence count, also the summed count of a merged node
	typedef logic [`HUFF_CNT_W-1:0] count_t;

	// set of symbols inside a node, bit 0 is symbol 1
	typedef logic [`HUFF_NUM_SYMBOLS-1:0] sym_mask_t;

	// code bits and valid-bit mask, both right-aligned
	typedef logic [`HUFF_CODE_W-1:0] code_t;
	typedef logic [`HUFF_CODE_W-1:0] len_mask_t;

endpackage

//--- logic/huff_settings.svh
`ifndef HUFF_SETTINGS_SVH
`define HUFF_SETTINGS_SVH

// symbol alphabet, gray values 1 to 6
`define HUFF_NUM_SYMBOLS 6

// datapath widths
`define HUFF_DATA_W 8
`define HUFF_CNT_W  8
`define HUFF_CODE_W 8

// one merge round fewer than symbols
`define HUFF_MERGES 5

`endif
